// File: hdl/fetch_if.sv
`timescale 1ns/10ps

// Item passed between fetch stages
interface fetch_stage_if #(
  parameter int WAY_BITS = 3
);
  logic                            valid;
  logic                            ready;
  logic [31:0]                     pc;
  logic                            hit;
  logic [WAY_BITS-1:0]             way;
  logic [fetch_pkg::LINE_BITS-1:0] line;

  modport source (output valid, pc, hit, way, line, input ready);
  modport sink   (input valid, pc, hit, way, line, output ready);
endinterface

// Line write from the refill logic into the cache arrays
interface cache_fill_if #(
  parameter int WAY_BITS = 3
);
  logic                             wen;
  logic [fetch_pkg::INDEX_BITS-1:0] index;
  logic [WAY_BITS-1:0]              way;
  logic [fetch_pkg::TAG_BITS-1:0]   tag;
  logic [fetch_pkg::LINE_BITS-1:0]  data;

  modport source (output wen, index, way, tag, data);
  modport sink   (input wen, index, way, tag, data);
endinterface

// File: hdl/fetch_pkg.sv
package fetch_pkg;

  // ------------------------------------------------
  // Cache geometry
  // ------------------------------------------------
  localparam int LINE_BYTES  = 16;
  localparam int LINE_WORDS  = 4;                     // 32-bit instructions per line
  localparam int INDEX_BITS  = 4;                     // 16 sets
  localparam int TAG_BITS    = 24;                    // Address bits 31:8
  localparam int LINE_BITS   = LINE_BYTES * 8;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);

  // ------------------------------------------------
  // AXI AR field widths
  // ------------------------------------------------
  localparam int AR_LEN_BITS   = 8;
  localparam int AR_SIZE_BITS  = 3;
  localparam int AR_BURST_BITS = 2;

  // Result stage FSM
  typedef enum logic [2:0] {
    IDLE,
    WAIT_ARREADY,
    WAIT_RVALID,
    HIT_READY,
    FILL_READY,
    CSR_WAIT,
    DRAIN             // Burst still running after a flush
  } drive_state_e;

endpackage

// File: hdl/ifetch_top.sv
`timescale 1ns/10ps

module ifetch_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_1000,
  parameter int          NUM_WAYS = 8
) (
  input  logic                                clock,
  input  logic                                reset,
  // Decode side
  output logic                                inst_valid_o,
  input  logic                                inst_ready_i,
  output logic [31:0]                         inst_o,
  output logic [31:0]                         pc_o,
  input  logic                                flush_i,
  input  logic [31:0]                         flush_pc_i,
  input  logic                                csr_wait_i,
  input  logic                                csr_commit_i,
  // AXI AR channel
  output logic                                arvalid_o,
  input  logic                                arready_i,
  output logic [31:0]                         araddr_o,
  output logic [fetch_pkg::AR_LEN_BITS-1:0]   arlen_o,
  output logic [fetch_pkg::AR_SIZE_BITS-1:0]  arsize_o,
  output logic [fetch_pkg::AR_BURST_BITS-1:0] arburst_o,
  // AXI R channel
  input  logic                                rvalid_i,
  output logic                                rready_o,
  input  logic [63:0]                         rdata_i,
  input  logic                                rlast_i
);

  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  fetch_stage_if #(.WAY_BITS(WAY_BITS)) pc_to_tag ();
  fetch_stage_if #(.WAY_BITS(WAY_BITS)) tag_to_res ();
  cache_fill_if  #(.WAY_BITS(WAY_BITS)) fill_bus ();

  // ------------------------------------------------
  // Fetch pipeline
  // ------------------------------------------------
  pc_gen #(.RESET_PC(RESET_PC)) pc_gen_inst (
    .clock      (clock),
    .reset      (reset),
    .flush_i    (flush_i),
    .flush_pc_i (flush_pc_i),
    .out        (pc_to_tag.source)
  );

  tag_lookup #(.NUM_WAYS(NUM_WAYS)) tag_lookup_inst (
    .clock   (clock),
    .reset   (reset),
    .flush_i (flush_i),
    .in      (pc_to_tag.sink),
    .out     (tag_to_res.source),
    .fill    (fill_bus.sink)
  );

  result_drive #(.NUM_WAYS(NUM_WAYS)) result_drive_inst (
    .clock        (clock),
    .reset        (reset),
    .flush_i      (flush_i),
    .csr_wait_i   (csr_wait_i),
    .csr_commit_i (csr_commit_i),
    .inst_ready_i (inst_ready_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .in           (tag_to_res.sink),
    .fill         (fill_bus.source),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid_o),
    .araddr_o     (araddr_o),
    .arlen_o      (arlen_o),
    .arsize_o     (arsize_o),
    .arburst_o    (arburst_o),
    .rvalid_i     (rvalid_i),
    .rready_o     (rready_o),
    .rdata_i      (rdata_i),
    .rlast_i      (rlast_i)
  );

endmodule

// File: hdl/pc_gen.sv
`timescale 1ns/10ps

module pc_gen #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          flush_i,
  input  logic [31:0]   flush_pc_i,
  fetch_stage_if.source out
);

  logic [31:0] pc_q;
  logic        xfer;

  assign xfer = out.valid && out.ready;

  // ------------------------------------------------
  // PC register
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;                // First fetch offered as reset drops
    end else if (flush_i) begin
      pc_q <= flush_pc_i;              // Redirect target goes out next cycle
    end else if (xfer) begin
      pc_q <= pc_q + 32'd4;            // Sequential fetch
    end
  end

  // Offered PC dropped in a flush cycle
  assign out.valid = !flush_i;
  assign out.pc    = pc_q;

  // No lookup result on this hop yet
  assign out.hit  = 1'b0;
  assign out.way  = '0;
  assign out.line = '0;

endmodule

// File: hdl/result_drive.sv
`timescale 1ns/10ps
`include "fetch_axi.svh"

module result_drive #(
  parameter int NUM_WAYS = 8
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  flush_i,
  input  logic                                  csr_wait_i,
  input  logic                                  csr_commit_i,
  input  logic                                  inst_ready_i,
  output logic                                  inst_valid_o,
  output logic [31:0]                           inst_o,
  output logic [31:0]                           pc_o,
  fetch_stage_if.sink                           in,
  cache_fill_if.source                          fill,
  // AXI read address
  input  logic                                  arready_i,
  output logic                                  arvalid_o,
  output logic [31:0]                           araddr_o,
  output logic [fetch_pkg::AR_LEN_BITS-1:0]     arlen_o,
  output logic [fetch_pkg::AR_SIZE_BITS-1:0]    arsize_o,
  output logic [fetch_pkg::AR_BURST_BITS-1:0]   arburst_o,
  // AXI read data
  input  logic                                  rvalid_i,
  output logic                                  rready_o,
  input  logic [63:0]                           rdata_i,
  input  logic                                  rlast_i
);

  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  localparam int OFF      = fetch_pkg::OFFSET_BITS;

  fetch_pkg::drive_state_e state_q;
  fetch_pkg::drive_state_e state_d;

  logic [31:0]                     pc_q;
  logic [fetch_pkg::LINE_BITS-1:0] line_q;        // Line buffer
  logic [1:0]                      beat_q;
  logic                            flush_pend_q;  // Flush seen before AR handshake
  logic [7:0]                      lfsr_q;
  logic [WAY_BITS-1:0]             fill_way_q;
  logic                            fill_wen_q;
  logic                            accept;
  logic                            deliver;
  logic                            ar_xfer;
  logic                            r_xfer;

  assign in.ready = (state_q == fetch_pkg::IDLE);
  assign accept   = in.valid && in.ready;
  assign deliver  = inst_valid_o && inst_ready_i;
  assign ar_xfer  = arvalid_o && arready_i;
  assign r_xfer   = rvalid_i && rready_o;

  // ------------------------------------------------
  // State machine
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_pkg::IDLE: begin
        if (accept && !flush_i) begin
          state_d = in.hit ? fetch_pkg::HIT_READY : fetch_pkg::WAIT_ARREADY;
        end
      end
      fetch_pkg::WAIT_ARREADY: begin
        if (arready_i) begin
          state_d = (flush_pend_q || flush_i) ? fetch_pkg::DRAIN : fetch_pkg::WAIT_RVALID;
        end
      end
      fetch_pkg::WAIT_RVALID: begin
        if (r_xfer && rlast_i) begin
          state_d = flush_i ? fetch_pkg::IDLE : fetch_pkg::FILL_READY;
        end else if (flush_i) begin
          state_d = fetch_pkg::DRAIN;
        end
      end
      fetch_pkg::HIT_READY, fetch_pkg::FILL_READY: begin
        if (flush_i) begin
          state_d = fetch_pkg::IDLE;     // Redirect discards the pending item
        end else if (deliver) begin
          state_d = csr_wait_i ? fetch_pkg::CSR_WAIT : fetch_pkg::IDLE;
        end
      end
      fetch_pkg::CSR_WAIT: begin
        if (csr_commit_i) state_d = fetch_pkg::IDLE;
      end
      fetch_pkg::DRAIN: begin
        if (r_xfer && rlast_i) state_d = fetch_pkg::IDLE;   // Line still gets written
      end
      default: state_d = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= fetch_pkg::IDLE;
      flush_pend_q <= 1'b0;
      beat_q       <= 2'd0;
      fill_wen_q   <= 1'b0;
      lfsr_q       <= 8'h5d;
    end else begin
      state_q    <= state_d;
      fill_wen_q <= r_xfer && rlast_i;    // One-cycle fill after the last beat
      lfsr_q     <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      if (ar_xfer) begin
        flush_pend_q <= 1'b0;
      end else if ((state_q == fetch_pkg::WAIT_ARREADY) && flush_i) begin
        flush_pend_q <= 1'b1;
      end
      if (r_xfer) begin
        beat_q <= rlast_i ? 2'd0 : beat_q + 2'd1;
      end
    end
  end

  // ------------------------------------------------
  // Line buffer and refill payload
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      pc_q   <= in.pc;
      line_q <= in.line;
    end else if (r_xfer) begin
      // Beat k carries words 2k and 2k+1; beats past the line end are dropped
      for (int w = 0; w < fetch_pkg::LINE_WORDS; w++) begin
        if (int'(beat_q) == w / 2) begin
          line_q[w*32 +: 32] <= rdata_i[(w % 2)*32 +: 32];
        end
      end
    end
    if (r_xfer && rlast_i) begin
      fill_way_q <= lfsr_q[WAY_BITS-1:0];   // Pseudo-random victim
    end
  end

  // Decode side
  assign inst_valid_o = ((state_q == fetch_pkg::HIT_READY) ||
                         (state_q == fetch_pkg::FILL_READY)) && !flush_i;
  assign inst_o       = line_q[{pc_q[OFF-1:2], 5'b00000} +: 32];
  assign pc_o         = pc_q;

  // Cache fill
  assign fill.wen   = fill_wen_q;
  assign fill.index = pc_q[OFF +: fetch_pkg::INDEX_BITS];
  assign fill.tag   = pc_q[31 -: fetch_pkg::TAG_BITS];
  assign fill.way   = fill_way_q;
  assign fill.data  = line_q;

  // AXI master
  assign arvalid_o = (state_q == fetch_pkg::WAIT_ARREADY);
  assign araddr_o  = {pc_q[31:OFF], {OFF{1'b0}}};   // Line aligned
  assign arlen_o   = `FETCH_AR_LEN;
  assign arsize_o  = `FETCH_AR_SIZE;
  assign arburst_o = `FETCH_AR_BURST;
  assign rready_o  = (state_q == fetch_pkg::WAIT_RVALID) || (state_q == fetch_pkg::DRAIN);

endmodule

// File: hdl/tag_lookup.sv
`timescale 1ns/10ps

module tag_lookup #(
  parameter int NUM_WAYS = 8
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          flush_i,
  fetch_stage_if.sink   in,
  fetch_stage_if.source out,
  cache_fill_if.sink    fill
);

  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  localparam int NUM_SETS = 1 << fetch_pkg::INDEX_BITS;
  localparam int IDX_LO   = fetch_pkg::OFFSET_BITS;
  localparam int IDX_HI   = fetch_pkg::OFFSET_BITS + fetch_pkg::INDEX_BITS - 1;

  // Cache arrays
  logic [NUM_WAYS-1:0]             valid_q [NUM_SETS];
  logic [fetch_pkg::TAG_BITS-1:0]  tag_q   [NUM_SETS][NUM_WAYS];
  logic [fetch_pkg::LINE_BITS-1:0] data_q  [NUM_SETS][NUM_WAYS];

  // Registered lookup result
  logic                            out_valid_q;
  logic [31:0]                     out_pc_q;
  logic                            out_hit_q;
  logic [WAY_BITS-1:0]             out_way_q;
  logic [fetch_pkg::LINE_BITS-1:0] out_line_q;

  logic [fetch_pkg::INDEX_BITS-1:0] lk_index;
  logic [fetch_pkg::TAG_BITS-1:0]   lk_tag;
  logic                             lk_hit;
  logic [WAY_BITS-1:0]              lk_way;
  logic                             accept;

  assign lk_index = in.pc[IDX_HI:IDX_LO];
  assign lk_tag   = in.pc[31 -: fetch_pkg::TAG_BITS];
  assign in.ready = !out_valid_q || out.ready;   // Hold under back-pressure
  assign accept   = in.valid && in.ready;

  // ------------------------------------------------
  // Hit compare across all ways of the set
  // ------------------------------------------------
  always_comb begin
    lk_hit = 1'b0;
    lk_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid_q[lk_index][w] && (tag_q[lk_index][w] == lk_tag)) begin
        lk_hit = 1'b1;
        lk_way = w[WAY_BITS-1:0];
      end
    end
  end

  // Valid bits and stage valid
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
      out_valid_q <= 1'b0;
    end else begin
      if (fill.wen) begin
        valid_q[fill.index][fill.way] <= 1'b1;
      end
      if (flush_i) begin
        out_valid_q <= 1'b0;             // Drop whatever was looked up
      end else if (accept) begin
        out_valid_q <= 1'b1;
      end else if (out.ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Tag and line storage
  always_ff @(posedge clock) begin
    if (fill.wen) begin
      tag_q[fill.index][fill.way]  <= fill.tag;
      data_q[fill.index][fill.way] <= fill.data;
    end
  end

  // Lookup payload
  always_ff @(posedge clock) begin
    if (accept) begin
      out_pc_q   <= in.pc;
      out_hit_q  <= lk_hit;
      out_way_q  <= lk_way;
      out_line_q <= data_q[lk_index][lk_way];   // Don't care on a miss
    end
  end

  assign out.valid = out_valid_q;
  assign out.pc    = out_pc_q;
  assign out.hit   = out_hit_q;
  assign out.way   = out_way_q;
  assign out.line  = out_line_q;

endmodule

// File: include/fetch_axi.svh
`ifndef FETCH_AXI_SVH
`define FETCH_AXI_SVH

// Line refill burst: four beats of 64 bits
`define FETCH_AR_LEN   8'd3

// 8 bytes per beat
`define FETCH_AR_SIZE  3'b011

// Incrementing burst
`define FETCH_AR_BURST 2'b01

`endif

// File: test/axi_mem_model.sv
`timescale 1ns/10ps
`include "fetch_axi.svh"

module axi_mem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic [1:0]  gap_i,           // Bit 0 holds off arready, bit 1 holds off rvalid
  input  logic        arvalid_i,
  output logic        arready_o,
  input  logic [31:0] araddr_i,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic [63:0] rdata_o,
  output logic        rlast_o
);

  localparam logic [31:0] MEM_KEY = 32'h5a5a_0013;

  logic        busy_q;
  logic [31:0] addr_q;
  logic [7:0]  beat_q;
  logic [31:0] beat_addr;

  // Instruction word stored at a byte address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_KEY;
  endfunction

  assign beat_addr = addr_q + {beat_q, 3'b000};   // 8 bytes per beat

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rlast_o   = 1'b0;
  end

  always @(posedge clock) begin
    if (reset) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rlast_o   <= 1'b0;
      busy_q    <= 1'b0;
      beat_q    <= 8'd0;
    end else begin
      // ------------------------------------------------
      // Address channel, one burst at a time
      // ------------------------------------------------
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        busy_q    <= 1'b1;
        addr_q    <= araddr_i;
        beat_q    <= 8'd0;
      end else begin
        arready_o <= !busy_q && !gap_i[0];
      end
      // Data channel
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        rlast_o  <= 1'b0;
        if (rlast_o) begin
          busy_q <= 1'b0;
        end else begin
          beat_q <= beat_q + 8'd1;
        end
      end else if (busy_q && !rvalid_o && !gap_i[1]) begin
        rvalid_o <= 1'b1;
        rdata_o  <= {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};  // Low word first
        rlast_o  <= (beat_q == `FETCH_AR_LEN);
      end
    end
  end

endmodule

// File: test/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;         // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// File: test/ifetch_props.sv
`timescale 1ns/10ps

// Hand-off and AXI request checks on the fetch top level
module ifetch_props (
  input logic        clock,
  input logic        reset,
  input logic        inst_valid_o,
  input logic        inst_ready_i,
  input logic [31:0] inst_o,
  input logic [31:0] pc_o,
  input logic        csr_wait_i,
  input logic        csr_commit_i,
  input logic        arvalid_o,
  input logic [31:0] araddr_o,
  input logic [7:0]  arlen_o,
  input logic [2:0]  arsize_o,
  input logic [1:0]  arburst_o,
  input logic        rready_o
);

  int unsigned fail_count = 0;
  logic        csr_hold_q;             // CSR taken, commit not seen yet

  always @(posedge clock) begin
    if (reset) begin
      csr_hold_q <= 1'b0;
    end else if (inst_valid_o && inst_ready_i && csr_wait_i) begin
      csr_hold_q <= 1'b1;
    end else if (csr_commit_i) begin
      csr_hold_q <= 1'b0;
    end
  end

  quiet_after_reset: assert property (@(posedge clock)
    reset |=> !inst_valid_o && !arvalid_o && !rready_o)
    else begin
      fail_count++;
      $error("Decode or AXI handshake active right after reset");
    end

  // Line-aligned INCR burst of four 8-byte beats
  ar_fields: assert property (@(posedge clock) disable iff (reset)
    arvalid_o |-> araddr_o[3:0] == 4'h0 && arlen_o == 8'd3 &&
                  arsize_o == 3'b011 && arburst_o == 2'b01)
    else begin
      fail_count++;
      $error("Line request with bad address or burst fields");
    end

  hold_under_stall: assert property (@(posedge clock) disable iff (reset)
    inst_valid_o && !inst_ready_i |=> $stable(inst_o) && $stable(pc_o))
    else begin
      fail_count++;
      $error("Instruction or PC changed while decode stalled");
    end

  csr_parks_fetch: assert property (@(posedge clock) disable iff (reset)
    csr_hold_q |-> !inst_valid_o)
    else begin
      fail_count++;
      $error("Instruction offered before the CSR commit");
    end

endmodule

bind ifetch_top ifetch_props ifetch_props_inst (.*);

// File: test/ifetch_tb.sv
`timescale 1ns/10ps

module ifetch_tb;

  localparam logic [31:0] RESET_PC       = 32'h0000_1000;
  localparam logic [31:0] MEM_KEY        = 32'h5a5a_0013;
  localparam logic [31:0] SEED           = 32'hb9a9f344;
  localparam int          TOTAL_INSTS    = 32 + 32 + 24 + 8 + 9;
  localparam int          TIMEOUT_CYCLES = 40 * TOTAL_INSTS;

  logic        clock;
  logic        reset;
  logic        inst_valid;
  logic        inst_ready;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        flush;
  logic [31:0] flush_pc;
  logic        csr_wait;
  logic        csr_commit;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic        rvalid;
  logic        rready;
  logic [63:0] rdata;
  logic        rlast;
  logic [31:0] rnd;
  logic [1:0]  mem_gap;
  logic        heavy_bp;               // 50 % ready instead of 75 %
  logic        refetch_on;             // Reset lines must stay resident
  logic [31:0] exp_pc;
  int          delivered = 0;
  int          errors = 0;
  int          tests_done = 0;

  clock_gen clock_gen_inst (.clock(clock), .reset(reset));

  axi_mem_model axi_mem_model_inst (
    .clock(clock), .reset(reset), .gap_i(mem_gap),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rlast_o(rlast)
  );

  ifetch_top #(.RESET_PC(RESET_PC), .NUM_WAYS(8)) ifetch_top_inst (
    .clock(clock), .reset(reset),
    .inst_valid_o(inst_valid), .inst_ready_i(inst_ready), .inst_o(inst), .pc_o(pc),
    .flush_i(flush), .flush_pc_i(flush_pc), .csr_wait_i(csr_wait), .csr_commit_i(csr_commit),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arlen_o(arlen),
    .arsize_o(arsize), .arburst_o(arburst),
    .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rlast_i(rlast)
  );

  // Single seeded source for decode ready and memory gaps
  initial begin
    void'($urandom(SEED));
    inst_ready = 1'b0;
    mem_gap    = 2'b00;
    forever begin
      @(posedge clock);
      rnd = $urandom;
      inst_ready <= heavy_bp ? rnd[6] : !(rnd[4] && rnd[5]);
      mem_gap    <= {rnd[2] && rnd[3], rnd[0] && rnd[1]};
    end
  end

  // Next PC decode should see
  always @(posedge clock) begin
    if (reset) begin
      exp_pc <= RESET_PC;
    end else if (flush) begin
      exp_pc <= flush_pc;
    end else if (inst_valid && inst_ready) begin
      exp_pc    <= exp_pc + 32'd4;
      delivered <= delivered + 1;
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  pc_order: assert property (@(posedge clock) disable iff (reset) inst_valid |-> pc == exp_pc)
    else begin
      errors++;
      $display("ERROR @%0t: pc_o %h, expected %h", $time, $sampled(pc), $sampled(exp_pc));
    end

  inst_rule: assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> inst == (pc ^ MEM_KEY))
    else begin
      errors++;
      $display("ERROR @%0t: inst_o %h at pc %h, expected %h", $time, $sampled(inst),
               $sampled(pc), $sampled(pc) ^ MEM_KEY);
    end

  no_refetch: assert property (@(posedge clock) disable iff (reset)
    refetch_on && arvalid && arready |-> araddr < RESET_PC || araddr >= RESET_PC + 32'h80)
    else begin
      errors++;
      $display("ERROR @%0t: resident line %h requested again", $time, $sampled(araddr));
    end

  function automatic int error_total();
    return errors + ifetch_top_inst.ifetch_props_inst.fail_count;
  endfunction

  task automatic fetch_insts(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) @(posedge clock);
  endtask

  task automatic redirect(input logic [31:0] target);
    flush    <= 1'b1;
    flush_pc <= target;
    @(posedge clock);
    flush    <= 1'b0;
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("Test %0d %s done at %0t, %0d delivered, %0d errors so far",
             tests_done, name, $time, delivered, error_total());
  endtask

  initial begin : stimulus
    flush      = 1'b0;
    flush_pc   = 32'h0;
    csr_wait   = 1'b0;
    csr_commit = 1'b0;
    heavy_bp   = 1'b0;
    refetch_on = 1'b0;
    @(posedge clock);
    while (reset) @(posedge clock);

    fetch_insts(32);                   // Eight cold lines from reset
    end_test("sequential_from_reset");
    refetch_on <= 1'b1;
    redirect(RESET_PC);
    fetch_insts(32);
    refetch_on <= 1'b0;
    end_test("resident_refetch");
    heavy_bp <= 1'b1;
    redirect(32'h0000_2000);
    fetch_insts(24);
    heavy_bp <= 1'b0;
    end_test("decode_backpressure");

    redirect(32'h0000_3000);
    while (!arvalid) @(posedge clock);
    redirect(32'h0000_3800);           // Line request still open
    while (!(rready && !rvalid)) @(posedge clock);
    redirect(32'h0000_3400);           // Burst in progress
    fetch_insts(8);
    end_test("flush_during_miss");

    csr_wait <= 1'b1;
    do @(posedge clock); while (!(inst_valid && inst_ready && csr_wait));
    csr_wait <= 1'b0;
    repeat (12) @(posedge clock);      // Fetch stays parked here
    csr_commit <= 1'b1;
    @(posedge clock);
    csr_commit <= 1'b0;
    fetch_insts(8);
    end_test("csr_wait");

    $display("Summary: %0d tests, %0d instructions delivered, %0d errors",
             tests_done, delivered, error_total());
    if (error_total() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: fetch did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/pc_gen.sv
hdl/tag_lookup.sv
hdl/result_drive.sv
hdl/ifetch_top.sv
test/clock_gen.sv
test/axi_mem_model.sv
test/ifetch_props.sv
test/ifetch_tb.sv
